/* hw/axil_rd_pkg.sv */
// ********************
// AXI-Lite read crossbar package.
// Widths, slave windows and shared types.
// ********************

`default_nettype none

package axil_rd_pkg;

    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int N_MST     = 2;
    localparam int N_SLV     = 2;
    localparam int MST_IDX_W = 1;
    localparam int SLV_IDX_W = 1;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [N_MST-1:0]  mst_mask_t;

    // One inclusive address window per slave.
    localparam addr_t SLV_BASE [N_SLV] = '{32'h43c0_0000, 32'h43c1_0000};
    localparam addr_t SLV_LAST [N_SLV] = '{32'h43c0_ffff, 32'h43c1_ffff};

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_DECERR = 2'b11
    } axil_resp_e;

    typedef enum logic [1:0] {
        RD_IDLE = 2'b00,
        RD_ADDR = 2'b01,
        RD_DATA = 2'b10
    } rd_state_e;

endpackage

`default_nettype wire

/* hw/axil_rd_if.sv */
// ********************
// AXI-Lite read channel.
// AR and R signals with master and slave views.
// ********************

`timescale 1ns/1ps
`default_nettype none

interface axil_rd_if
    import axil_rd_pkg::*;
();

    addr_t      araddr;
    logic       arvalid;
    logic       arready;
    data_t      rdata;
    axil_resp_e rresp;
    logic       rvalid;
    logic       rready;

    modport master (
        output araddr, arvalid, rready,
        input  arready, rdata, rresp, rvalid
    );

    modport slave (
        input  araddr, arvalid, rready,
        output arready, rdata, rresp, rvalid
    );

endinterface

`default_nettype wire

/* hw/rr_arbiter.sv */
// ********************
// Round-robin arbiter.
// Grants the first requester at or after the priority pointer.
// ********************

`timescale 1ns/1ps
`default_nettype none

module rr_arbiter
    import axil_rd_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rstn_i,
    input  wire mst_mask_t req_i,
    input  wire logic      take_i,
    output mst_mask_t      grant_o
);

    logic [MST_IDX_W-1:0] ptr_q;
    logic [MST_IDX_W-1:0] gnt_idx;

    always_comb begin
        int   idx;
        logic found;
        grant_o = '0;
        gnt_idx = '0;
        found   = 1'b0;
        for (int i = 0; i < N_MST; i++) begin
            idx = int'(ptr_q) + i;
            if (idx >= N_MST) begin
                idx = idx - N_MST; // Wrap past the last master.
            end
            if (req_i[idx] && !found) begin
                grant_o[idx] = 1'b1;
                gnt_idx      = MST_IDX_W'(idx);
                found        = 1'b1;
            end
        end
    end

    // Pointer moves past the master that was just served.
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ptr_q <= '0;
        end else if (take_i) begin
            ptr_q <= (int'(gnt_idx) == N_MST - 1) ? '0 : gnt_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/rd_router.sv */
// ********************
// Read router.
// Decodes the granted address, steers AR and R,
// and answers unmapped reads with DECERR.
// ********************

`timescale 1ns/1ps
`default_nettype none

module rd_router
    import axil_rd_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  rstn_i,
    axil_rd_if.slave   mst [N_MST],
    axil_rd_if.master  slv [N_SLV],
    output mst_mask_t  req_o,
    input  wire mst_mask_t grant_i,
    output logic       take_o
);

    function automatic logic [MST_IDX_W-1:0] onehot_to_idx(input mst_mask_t oh);
        logic [MST_IDX_W-1:0] idx;
        idx = '0;
        for (int i = 0; i < N_MST; i++) begin
            if (oh[i]) begin
                idx = MST_IDX_W'(i);
            end
        end
        return idx;
    endfunction

    // Windows are checked in order and the first hit wins.
    function automatic logic [SLV_IDX_W:0] decode(input addr_t addr);
        logic [SLV_IDX_W:0] res;
        res = '0;
        for (int i = N_SLV - 1; i >= 0; i--) begin
            if (addr >= SLV_BASE[i] && addr <= SLV_LAST[i]) begin
                res = {1'b1, SLV_IDX_W'(i)};
            end
        end
        return res;
    endfunction

    addr_t      mst_araddr  [N_MST];
    logic       mst_arvalid [N_MST];
    logic       mst_rready  [N_MST];
    logic       mst_arready [N_MST];
    data_t      mst_rdata   [N_MST];
    axil_resp_e mst_rresp   [N_MST];
    logic       mst_rvalid  [N_MST];

    addr_t      slv_araddr  [N_SLV];
    logic       slv_arvalid [N_SLV];
    logic       slv_rready  [N_SLV];
    logic       slv_arready [N_SLV];
    data_t      slv_rdata   [N_SLV];
    axil_resp_e slv_rresp   [N_SLV];
    logic       slv_rvalid  [N_SLV];

    for (genvar i = 0; i < N_MST; i++) begin : g_mst
        assign mst_araddr[i]  = mst[i].araddr;
        assign mst_arvalid[i] = mst[i].arvalid;
        assign mst_rready[i]  = mst[i].rready;
        assign mst[i].arready = mst_arready[i];
        assign mst[i].rdata   = mst_rdata[i];
        assign mst[i].rresp   = mst_rresp[i];
        assign mst[i].rvalid  = mst_rvalid[i];
        assign req_o[i]       = mst_arvalid[i];
    end

    for (genvar i = 0; i < N_SLV; i++) begin : g_slv
        assign slv[i].araddr  = slv_araddr[i];
        assign slv[i].arvalid = slv_arvalid[i];
        assign slv[i].rready  = slv_rready[i];
        assign slv_arready[i] = slv[i].arready;
        assign slv_rdata[i]   = slv[i].rdata;
        assign slv_rresp[i]   = slv[i].rresp;
        assign slv_rvalid[i]  = slv[i].rvalid;
    end

    rd_state_e            state_q, state_d;
    logic [MST_IDX_W-1:0] gnt_idx, gnt_idx_q;
    logic [SLV_IDX_W:0]   dec;
    logic [SLV_IDX_W-1:0] dec_idx_q;
    logic                 dec_vld_q;

    assign gnt_idx = onehot_to_idx(grant_i);
    assign dec     = decode(mst_araddr[gnt_idx]);
    assign take_o  = (state_q == RD_IDLE) && |grant_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q   <= RD_IDLE;
            gnt_idx_q <= '0;
            dec_idx_q <= '0;
            dec_vld_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (take_o) begin
                gnt_idx_q <= gnt_idx;
                dec_idx_q <= dec[SLV_IDX_W-1:0];
                dec_vld_q <= dec[SLV_IDX_W];
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            RD_IDLE: begin
                if (take_o) begin
                    state_d = RD_ADDR;
                end
            end
            RD_ADDR: begin
                // Unmapped address is accepted locally in one cycle.
                if (!dec_vld_q || (slv_arvalid[dec_idx_q] && slv_arready[dec_idx_q])) begin
                    state_d = RD_DATA;
                end
            end
            RD_DATA: begin
                if (mst_rvalid[gnt_idx_q] && mst_rready[gnt_idx_q]) begin
                    state_d = RD_IDLE;
                end
            end
            default: state_d = RD_IDLE;
        endcase
    end

    // Only the decoded slave sees traffic.
    always_comb begin
        for (int i = 0; i < N_SLV; i++) begin
            slv_araddr[i]  = '0;
            slv_arvalid[i] = 1'b0;
            slv_rready[i]  = 1'b0;
        end
        if (dec_vld_q) begin
            if (state_q == RD_ADDR) begin
                slv_araddr[dec_idx_q]  = mst_araddr[gnt_idx_q];
                slv_arvalid[dec_idx_q] = mst_arvalid[gnt_idx_q];
            end else if (state_q == RD_DATA) begin
                slv_rready[dec_idx_q] = mst_rready[gnt_idx_q];
            end
        end
    end

    // Master side.
    always_comb begin
        for (int i = 0; i < N_MST; i++) begin
            mst_arready[i] = 1'b0;
            mst_rdata[i]   = '0;
            mst_rresp[i]   = RESP_OKAY;
            mst_rvalid[i]  = 1'b0;
        end
        if (state_q == RD_ADDR) begin
            mst_arready[gnt_idx_q] = dec_vld_q ? slv_arready[dec_idx_q] : 1'b1;
        end else if (state_q == RD_DATA) begin
            if (dec_vld_q) begin
                mst_rvalid[gnt_idx_q] = slv_rvalid[dec_idx_q];
                mst_rresp[gnt_idx_q]  = slv_rresp[dec_idx_q];
                mst_rdata[gnt_idx_q]  = slv_rdata[dec_idx_q];
            end else begin
                mst_rvalid[gnt_idx_q] = 1'b1;
                mst_rresp[gnt_idx_q]  = RESP_DECERR; // Data stays zero.
            end
        end
    end

endmodule

`default_nettype wire

/* hw/axil_rd_xbar.sv */
// ********************
// AXI-Lite read crossbar top.
// Two masters share one arbitrated read path to two slaves.
// ********************

`timescale 1ns/1ps
`default_nettype none

module axil_rd_xbar
    import axil_rd_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rstn_i,

    input  wire addr_t      mst_araddr_i  [N_MST],
    input  wire logic       mst_arvalid_i [N_MST],
    input  wire logic       mst_rready_i  [N_MST],
    output logic            mst_arready_o [N_MST],
    output data_t           mst_rdata_o   [N_MST],
    output axil_resp_e      mst_rresp_o   [N_MST],
    output logic            mst_rvalid_o  [N_MST],

    output addr_t           slv_araddr_o  [N_SLV],
    output logic            slv_arvalid_o [N_SLV],
    output logic            slv_rready_o  [N_SLV],
    input  wire logic       slv_arready_i [N_SLV],
    input  wire data_t      slv_rdata_i   [N_SLV],
    input  wire axil_resp_e slv_rresp_i   [N_SLV],
    input  wire logic       slv_rvalid_i  [N_SLV]
);

    axil_rd_if mst_if [N_MST] ();
    axil_rd_if slv_if [N_SLV] ();

    mst_mask_t req;
    mst_mask_t grant;
    logic      take;

    for (genvar i = 0; i < N_MST; i++) begin : g_mst
        assign mst_if[i].araddr  = mst_araddr_i[i];
        assign mst_if[i].arvalid = mst_arvalid_i[i];
        assign mst_if[i].rready  = mst_rready_i[i];
        assign mst_arready_o[i]  = mst_if[i].arready;
        assign mst_rdata_o[i]    = mst_if[i].rdata;
        assign mst_rresp_o[i]    = mst_if[i].rresp;
        assign mst_rvalid_o[i]   = mst_if[i].rvalid;
    end

    for (genvar i = 0; i < N_SLV; i++) begin : g_slv
        assign slv_araddr_o[i]   = slv_if[i].araddr;
        assign slv_arvalid_o[i]  = slv_if[i].arvalid;
        assign slv_rready_o[i]   = slv_if[i].rready;
        assign slv_if[i].arready = slv_arready_i[i];
        assign slv_if[i].rdata   = slv_rdata_i[i];
        assign slv_if[i].rresp   = slv_rresp_i[i];
        assign slv_if[i].rvalid  = slv_rvalid_i[i];
    end

    rr_arbiter rr_arbiter_inst (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .req_i  (req),
        .take_i (take),
        .grant_o(grant)
    );

    rd_router rd_router_inst (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .mst    (mst_if),
        .slv    (slv_if),
        .req_o  (req),
        .grant_i(grant),
        .take_o (take)
    );

endmodule

`default_nettype wire

/* tests/tb_axil_rd_xbar.sv */
// ********************
// Testbench for the AXI-Lite read crossbar.
// Replays reads from a case file against two slave models.
// ********************

`timescale 1ns/1ps
`default_nettype none

module tb_axil_rd_xbar
    import axil_rd_pkg::*;
();

    localparam int    MAX_CASES = 64;
    localparam int    TIMEOUT   = 200;
    localparam int    POOL      = 256;
    localparam data_t TAG [N_SLV] = '{32'h5a5a_0000, 32'h0000_a5a5};

    logic       clk_i  = 1'b0;
    logic       rstn_i = 1'b0;
    addr_t      mst_araddr  [N_MST] = '{default: '0};
    logic       mst_arvalid [N_MST] = '{default: 1'b0};
    logic       mst_rready  [N_MST] = '{default: 1'b0};
    logic       mst_arready [N_MST];
    data_t      mst_rdata   [N_MST];
    axil_resp_e mst_rresp   [N_MST];
    logic       mst_rvalid  [N_MST];
    addr_t      slv_araddr  [N_SLV];
    logic       slv_arvalid [N_SLV];
    logic       slv_rready  [N_SLV];
    logic       slv_arready [N_SLV] = '{default: 1'b0};
    data_t      slv_rdata   [N_SLV] = '{default: '0};
    axil_resp_e slv_rresp   [N_SLV] = '{default: RESP_OKAY};
    logic       slv_rvalid  [N_SLV] = '{default: 1'b0};

    // Copies taken at the rising edge.
    logic       m_ar_hs     [N_MST];
    logic       m_r_hs      [N_MST];
    logic       m_rvalid_q  [N_MST];
    data_t      m_rdata_q   [N_MST];
    axil_resp_e m_rresp_q   [N_MST];
    logic       s_arvalid_q [N_SLV];
    logic       s_ar_hs     [N_SLV];
    logic       s_r_hs      [N_SLV];
    addr_t      s_addr_q    [N_SLV];
    logic       s_ar_open   [N_SLV] = '{default: 1'b0};

    integer seed = 32'h68f2_b67e;
    int     pool [POOL];
    int     pool_idx = 0;
    int     ph  [N_SLV] = '{default: 0};
    int     cnt [N_SLV] = '{default: 0};
    int     errors = 0;
    int     slv_errors = 0;
    int     accepts = 0;
    int     ar_starts = 0;
    int     n_cases = 0;
    int     c_grp   [MAX_CASES];
    int     c_mst   [MAX_CASES];
    addr_t  c_addr  [MAX_CASES];
    int     c_stall [MAX_CASES];
    string  c_resp  [MAX_CASES];
    int     done_order [$];

    axil_rd_xbar axil_rd_xbar_inst (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .mst_araddr_i (mst_araddr),
        .mst_arvalid_i(mst_arvalid),
        .mst_rready_i (mst_rready),
        .mst_arready_o(mst_arready),
        .mst_rdata_o  (mst_rdata),
        .mst_rresp_o  (mst_rresp),
        .mst_rvalid_o (mst_rvalid),
        .slv_araddr_o (slv_araddr),
        .slv_arvalid_o(slv_arvalid),
        .slv_rready_o (slv_rready),
        .slv_arready_i(slv_arready),
        .slv_rdata_i  (slv_rdata),
        .slv_rresp_i  (slv_rresp),
        .slv_rvalid_i (slv_rvalid)
    );

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        for (int i = 0; i < N_MST; i++) begin
            m_ar_hs[i]    = mst_arvalid[i] && mst_arready[i];
            m_r_hs[i]     = mst_rvalid[i] && mst_rready[i];
            m_rvalid_q[i] = mst_rvalid[i];
            m_rdata_q[i]  = mst_rdata[i];
            m_rresp_q[i]  = mst_rresp[i];
        end
        for (int i = 0; i < N_SLV; i++) begin
            if (slv_arvalid[i] && !s_ar_open[i]) begin
                ar_starts++; // A new request reaches this slave.
            end
            s_ar_open[i]   = slv_arvalid[i] && !slv_arready[i];
            s_arvalid_q[i] = slv_arvalid[i];
            s_ar_hs[i]     = slv_arvalid[i] && slv_arready[i];
            s_r_hs[i]      = slv_rvalid[i] && slv_rready[i];
            s_addr_q[i]    = slv_araddr[i];
        end
    end

    // Slave models with random arready and rvalid delays.
    always @(negedge clk_i) begin
        for (int s = 0; s < N_SLV; s++) begin
            case (ph[s])
                0: begin
                    if (s_arvalid_q[s] && cnt[s] == 0) begin
                        slv_arready[s] = 1'b1;
                        ph[s] = 1;
                    end else if (s_arvalid_q[s]) begin
                        cnt[s]--;
                    end
                end
                1: begin
                    if (s_ar_hs[s]) begin
                        slv_arready[s] = 1'b0;
                        accepts++;
                        if (s_addr_q[s][31:16] != 16'h43c0 + 16'(s)) begin
                            $display("[ERROR] slv_araddr_o[%0d] got %h outside its window",
                                     s, s_addr_q[s]);
                            slv_errors++;
                        end
                        slv_rdata[s] = s_addr_q[s] ^ TAG[s];
                        cnt[s] = pool[pool_idx % POOL];
                        pool_idx++;
                        ph[s] = 2;
                    end
                end
                2: begin
                    if (cnt[s] == 0) begin
                        slv_rvalid[s] = 1'b1;
                        ph[s] = 3;
                    end else begin
                        cnt[s]--;
                    end
                end
                3: begin
                    if (s_r_hs[s]) begin
                        slv_rvalid[s] = 1'b0;
                        slv_rdata[s]  = '0;
                        cnt[s] = pool[pool_idx % POOL];
                        pool_idx++;
                        ph[s] = 0;
                    end
                end
                default: ph[s] = 0;
            endcase
        end
    end

    task automatic check_resp(input string name, input axil_resp_e got, input axil_resp_e exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic expect_idle_ports(input string when);
        for (int i = 0; i < N_MST; i++) begin
            if (mst_arready[i] || mst_rvalid[i]) begin
                $display("Master port %0d shows arready or rvalid %s", i, when);
                errors++;
            end
        end
        for (int i = 0; i < N_SLV; i++) begin
            if (slv_arvalid[i] || slv_rready[i]) begin
                $display("Slave port %0d shows arvalid or rready %s", i, when);
                errors++;
            end
        end
    endtask

    task automatic run_read(input int m, input int c);
        int         t;
        int         stall;
        int         err0;
        axil_resp_e exp_resp;
        data_t      exp_data;
        data_t      held_data;
        axil_resp_e held_resp;
        err0     = errors;
        exp_resp = (c_resp[c] == "DECERR") ? RESP_DECERR : RESP_OKAY;
        // Bit 16 picks the 64 KiB window of slave 1.
        exp_data = (exp_resp == RESP_OKAY) ? (c_addr[c] ^ TAG[c_addr[c][16]]) : '0;
        mst_araddr[m]  = c_addr[c];
        mst_arvalid[m] = 1'b1;
        t = 0;
        do begin
            @(negedge clk_i);
            t++;
        end while (!m_ar_hs[m] && t < TIMEOUT);
        mst_arvalid[m] = 1'b0;
        mst_araddr[m]  = '0;
        if (!m_ar_hs[m]) begin
            $display("Master %0d timed out waiting for arready in case %0d", m, c);
            errors++;
            return;
        end
        t = 0;
        while (!m_rvalid_q[m] && t < TIMEOUT) begin
            @(negedge clk_i);
            t++;
        end
        if (!m_rvalid_q[m]) begin
            $display("Master %0d timed out waiting for rvalid in case %0d", m, c);
            errors++;
            return;
        end
        held_data = m_rdata_q[m];
        held_resp = m_rresp_q[m];
        stall = $unsigned($random(seed)) % (c_stall[c] + 1);
        repeat (stall) begin
            @(negedge clk_i);
            if (!m_rvalid_q[m]) begin
                $display("Master %0d lost rvalid while holding rready low", m);
                errors++;
            end
            check_data($sformatf("mst_rdata_o[%0d]", m), m_rdata_q[m], held_data);
            check_resp($sformatf("mst_rresp_o[%0d]", m), m_rresp_q[m], held_resp);
        end
        mst_rready[m] = 1'b1;
        t = 0;
        do begin
            @(negedge clk_i);
            t++;
        end while (!m_r_hs[m] && t < TIMEOUT);
        mst_rready[m] = 1'b0;
        if (!m_r_hs[m]) begin
            $display("Master %0d timed out waiting for the R handshake in case %0d", m, c);
            errors++;
        end else begin
            done_order.push_back(m);
            check_resp($sformatf("mst_rresp_o[%0d]", m), m_rresp_q[m], exp_resp);
            check_data($sformatf("mst_rdata_o[%0d]", m), m_rdata_q[m], exp_data);
        end
        $display("case %0d master %0d addr %h stall %0d: %s", c, m, c_addr[c], stall,
                 (errors == err0) ? "ok" : "failed");
    endtask

    initial begin
        int    fd;
        string line;
        int    g;
        int    m;
        int    st;
        int    k;
        int    base;
        int    ptr_model;
        int    n_okay;
        int    idx [N_MST];
        addr_t a;
        string r;
        for (k = 0; k < POOL; k++) begin
            pool[k] = $unsigned($random(seed)) % 4;
        end
        fd = $fopen("tests/rd_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open tests/rd_cases.txt");
            errors++;
        end else begin
            while (!$feof(fd) && n_cases < MAX_CASES) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#" &&
                    $sscanf(line, "%d %d %h %d %s", g, m, a, st, r) == 5) begin
                    c_grp[n_cases]   = g;
                    c_mst[n_cases]   = m;
                    c_addr[n_cases]  = a;
                    c_stall[n_cases] = st;
                    c_resp[n_cases]  = r;
                    n_cases++;
                end
            end
            $fclose(fd);
        end
        repeat (4) begin
            @(posedge clk_i);
            expect_idle_ports("during reset");
        end
        @(negedge clk_i);
        rstn_i = 1'b1;
        repeat (2) begin
            @(posedge clk_i);
            expect_idle_ports("after reset");
        end
        ptr_model = 0; // Arbiter favors master 0 out of reset.
        n_okay = 0;
        k = 0;
        while (k < n_cases) begin
            idx[0] = -1;
            idx[1] = -1;
            g = c_grp[k];
            while (k < n_cases && c_grp[k] == g) begin
                idx[c_mst[k]] = k;
                n_okay += (c_resp[k] == "OKAY") ? 1 : 0;
                k++;
            end
            @(negedge clk_i);
            base = done_order.size();
            fork
                if (idx[0] >= 0) run_read(0, idx[0]);
                if (idx[1] >= 0) run_read(1, idx[1]);
            join
            if (idx[0] >= 0 && idx[1] >= 0 && done_order.size() == base + 2 &&
                done_order[base] != ptr_model) begin
                $display("Group %0d served master %0d first where master %0d was due",
                         g, done_order[base], ptr_model);
                errors++;
            end
            if (done_order.size() > base) begin
                ptr_model = (done_order[done_order.size() - 1] + 1) % N_MST;
            end
        end
        if (n_cases == 0 || accepts != n_okay || ar_starts != n_okay) begin
            $display("Slaves saw %0d requests and accepted %0d where %0d were expected",
                     ar_starts, accepts, n_okay);
            errors++;
        end
        $display("%0d cases run, %0d errors", n_cases, errors + slv_errors);
        if (errors + slv_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/rd_cases.txt */
# group master address(hex) max_rready_stall expected_resp
# Lines with the same group start in the same cycle.
0 0 43c00010 3 OKAY
0 1 43c10020 0 OKAY
1 0 43c1ff00 0 OKAY
2 0 43c00300 2 OKAY
2 1 43c10400 4 OKAY
3 1 43c0fffc 1 OKAY
4 1 43c1fffc 0 OKAY
5 0 50000000 0 DECERR
6 1 43c20000 3 DECERR
7 0 43bffffc 0 DECERR
8 0 43c0beec 5 OKAY
8 1 00000000 2 DECERR
9 1 43c17ff0 0 OKAY
10 0 43c1aaa8 6 OKAY
10 1 43c00500 3 OKAY
11 1 ffffffff 0 DECERR
12 0 43c00000 2 OKAY
12 1 43c1ffff 5 OKAY

/* verilog.f */
hw/axil_rd_pkg.sv
hw/axil_rd_if.sv
hw/rr_arbiter.sv
hw/rd_router.sv
hw/axil_rd_xbar.sv
tests/tb_axil_rd_xbar.sv

/* Makefile */
SIM    ?= verilator
FLAGS  ?= --binary --timing -j 0
TOP    ?= tb_axil_rd_xbar
FLIST  ?= verilog.f
OBJDIR ?= obj_dir

BIN  = $(OBJDIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJDIR)
